/* filelist.f */
src/rng_pkg.sv
src/raw_noise_source.sv
src/seed_conditioner.sv
src/drbg.sv
src/output_buffer.sv
src/rng_top.sv
+incdir+sim
sim/tb_rng_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the RNG unit testbench with Verilator and run it

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal \
    --top-module tb_rng_top \
    -f filelist.f \
    -Mdir obj_dir -o sim_rng
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_rng
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0

/* sim/rng_ref_model.svh */
//####################
// RNG reference model
//####################
`ifndef RNG_REF_MODEL_SVH
`define RNG_REF_MODEL_SVH

localparam int N_SEEDS = 250;          // 50 DRBG seeds and 200 queue seeds
localparam int N_QSEED = 200;
localparam int N_BLK   = 200;
localparam int N_RAW_B = 320;

seed_t     q_seeds [N_QSEED];          // Queue-bound seeds in order
rand_blk_t d_blks  [N_BLK];            // DRBG output blocks in order
raw_word_t raw_b_m [N_RAW_B];          // Source B words in order

int qp;      // Queue seeds fully used
int spos;    // Slice position in head seed
int db;      // DRBG blocks handed to the buffer, current one included
int rb;      // Source B words handed to the buffer
int rpos;    // Slice position in RDRAND buffer
bit cur_raw; // Current buffer came from source B
int demand;

// 64 Galois steps per word with taps from x^64+x^63+x^61+x^60+1
function automatic raw_word_t lfsr_step64(raw_word_t s);
    raw_word_t x;
    x = s;
    for (int i = 0; i < 64; i++) begin
        if (x[0]) x = (x >> 1) ^ 64'hD800_0000_0000_0000;
        else x = x >> 1;
    end
    return x;
endfunction

function automatic raw_word_t rotate_mix(raw_word_t x);
    return (x << 13) | (x >> 51);
endfunction

// Word i XOR rotated word i+1 where word 3 wraps to word 0 and word 0 is lowest
function automatic seed_t mix_seed(raw_word_t w [4]);
    seed_t s;
    for (int i = 0; i < 4; i++) begin
        s[i*64 +: 64] = w[i] ^ rotate_mix(w[(i + 1) % 4]);
    end
    return s;
endfunction

function automatic rand_blk_t drbg_next(rand_blk_t s);
    rand_blk_t rot;
    rot = (s << 33) | (s >> 95);
    return rot ^ (s + DRBG_ROUND_K);
endfunction

task automatic build_streams();
    raw_word_t a;
    raw_word_t b;
    raw_word_t w [4];
    seed_t     s;
    rand_blk_t st;
    int        nq;
    int        nd;
    a  = RAW_A_INIT;
    nq = 0;
    nd = 0;
    for (int k = 0; k < N_SEEDS; k++) begin
        for (int i = 0; i < 4; i++) begin
            w[i] = a;
            a    = lfsr_step64(a);
        end
        s = mix_seed(w);
        if (k % 5 == 0) begin
            st = s[255:128] ^ s[127:0];
            for (int i = 0; i < 4; i++) begin
                d_blks[nd*4 + i] = st ^ DRBG_ROUND_K;
                st = drbg_next(st);
            end
            nd++;
        end else begin
            q_seeds[nq] = s;
            nq++;
        end
    end
    b = RAW_B_INIT;
    for (int i = 0; i < N_RAW_B; i++) begin
        raw_b_m[i] = b;
        b = lfsr_step64(b);
    end
    qp      = 0;
    spos    = 0;
    db      = 1;
    rb      = 0;
    rpos    = 0;
    cur_raw = 1'b0;
    demand  = 0;
endtask

// Seeds that the conditioner can hand out, given what has been consumed
function automatic void seeds_ready(input int qpop, input int taken,
                                    output int nd, output int nq);
    int k;
    bit stop;
    nd   = 0;
    nq   = 0;
    k    = 0;
    stop = 1'b0;
    while (!stop && k < N_SEEDS) begin
        if (k % 5 == 0) begin
            if (taken >= 4 * (k / 5)) nd++; // DRBG must be exhausted
            else stop = 1'b1;
        end else begin
            if (nq < qpop + 4) nq++;
            else stop = 1'b1;
        end
        k++;
    end
endfunction

function automatic void supply(input int qpop, input int dblk, input bit raw_now,
                               output int nd, output int nq);
    seeds_ready(qpop, raw_now ? dblk : dblk - 1, nd, nq);
    if (!raw_now && dblk - 1 < 4 * nd) seeds_ready(qpop, dblk, nd, nq); // Prefetch
endfunction

function automatic bit next_raw(bit force_raw, int dem);
    return force_raw || (dem >= RAW_THRESHOLD);
endfunction

function automatic int demand_after(bit is_rand, int dem);
    if (is_rand) return (dem == 63) ? 63 : dem + 1;
    return (dem == 0) ? 0 : dem - 1;
endfunction

// Request can finish without a stall between seed queue and DRBG
function automatic bit can_finish(bit is_rand, int n, bit force_raw);
    int nd;
    int nq;
    int p;
    int d;
    int dem;
    bit r;
    if (!is_rand) begin
        supply(qp, db, cur_raw, nd, nq);
        return (qp*16 + spos + n) <= nq*16;
    end
    p   = rpos;
    d   = db;
    r   = cur_raw;
    dem = demand_after(1'b1, demand);
    for (int i = 0; i < n; i++) begin
        supply(qp, d, r, nd, nq);
        if (!r && d - 1 >= 4 * nd) return 1'b0;
        p++;
        if (p == 8) begin
            p = 0;
            r = next_raw(force_raw, dem);
            if (!r) d++;
        end
    end
    return 1'b1;
endfunction

function automatic logic [15:0] take_word(bit is_rand, bit force_raw);
    logic [15:0] w;
    rand_blk_t   blk;
    if (!is_rand) begin
        w = q_seeds[qp][spos*16 +: 16];
        spos++;
        if (spos == 16) begin
            spos = 0;
            qp++;
        end
    end else begin
        blk = cur_raw ? {raw_b_m[rb-1], raw_b_m[rb-2]} : d_blks[db-1]; // First word low
        w = blk[rpos*16 +: 16];
        rpos++;
        if (rpos == 8) begin
            rpos    = 0;
            cur_raw = next_raw(force_raw, demand);
            if (cur_raw) rb += 2;
            else db++;
        end
    end
    return w;
endfunction

`endif

/* sim/tb_rng_top.sv */
//####################
// RNG unit testbench
//####################
`timescale 1ns/10ps
`default_nettype none

module tb_rng_top;
    import rng_pkg::*;

    localparam raw_word_t RAW_A_INIT    = 64'h5DEE_CE66_D1CE_4E5B;
    localparam raw_word_t RAW_B_INIT    = 64'hA5A5_3C3C_0F0F_9669;
    localparam int        RAW_THRESHOLD = 12;
    localparam int        N_REQ         = 300;
    localparam int        WATCHDOG_CYC  = N_REQ * (20 + 400);

    logic        clk;
    logic        rst_n;
    logic        force_raw_i;
    logic        req_i;
    rand_req_t   req_type_i;
    logic [15:0] word_o;
    logic        word_valid_o;
    logic        busy_o;
    logic [31:0] rng_q;

    `include "rng_ref_model.svh"

    rng_top u_dut (
        .clk, .rst_n, .force_raw_i, .req_i, .req_type_i,
        .word_o, .word_valid_o, .busy_o);

    always #50 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_q = rng_q ^ (rng_q << 13);
        rng_q = rng_q ^ (rng_q >> 17);
        rng_q = rng_q ^ (rng_q << 5);
        return rng_q;
    endfunction

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // One request from pulse to busy_o low
    task automatic run_request(input bit is_rand, input int cnt, input bit force_raw);
        int          words;
        logic [15:0] exp;
        force_raw_i = force_raw;
        req_type_i  = rand_req_t'({is_rand, (cnt == 4) ? 2'b11 : 2'(cnt)});
        req_i       = 1'b1;
        demand      = demand_after(is_rand, demand);
        words       = 0;
        @(negedge clk);
        req_i = 1'b0;
        while (words < cnt) begin
            check_eq(busy_o, 1'b1, "busy during request");
            if (word_valid_o) begin
                exp = take_word(is_rand, force_raw);
                check_eq(word_o, exp, is_rand ? "RDRAND word" : "RDSEED word");
                words++;
            end
            @(negedge clk);
        end
        check_eq(busy_o, 1'b0, "busy after last word");
        check_eq(word_valid_o, 1'b0, "extra word");
    endtask

    initial begin
        int        gap;
        int        cnt;
        bit        is_rand;
        bit        force_raw;
        clk         = 1'b0;
        rst_n       = 1'b0;
        force_raw_i = 1'b0;
        req_i       = 1'b0;
        req_type_i  = RDSEED_16;
        rng_q       = 32'h2a7a5f52;
        build_streams();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        check_eq(word_valid_o, 1'b0, "word valid after reset");
        check_eq(busy_o, 1'b0, "busy after reset");

        for (int r = 0; r < N_REQ; r++) begin
            gap = next_rand() % 21;
            repeat (gap) begin
                @(negedge clk);
                check_eq(word_valid_o, 1'b0, "word while idle");
            end
            if (r >= 100 && r < 140) begin       // RDRAND run pushes demand past threshold
                is_rand   = 1'b1;
                cnt       = 4;
                force_raw = 1'b0;
            end else if (r >= 140 && r < 180) begin
                is_rand   = 1'b0;
                cnt       = 4;
                force_raw = 1'b0;
            end else begin
                force_raw = (next_rand() % 4 == 0);
                is_rand   = next_rand() % 2;
                cnt       = 1 << (next_rand() % 3);
            end
            // Swap to a request that cannot stall the queue and DRBG against each other
            if (!can_finish(is_rand, cnt, force_raw)) begin
                is_rand = !is_rand;
                if (!can_finish(is_rand, cnt, force_raw)) cnt = 1;
                if (!can_finish(is_rand, cnt, force_raw)) is_rand = !is_rand;
                if (!can_finish(is_rand, cnt, force_raw)) begin
                    $display("No request type can complete at %0t ns", $time);
                    $display("Test FAILED");
                    $fatal(1, "stimulus stalled");
                end
            end
            run_request(is_rand, cnt, force_raw);
        end
        $display("Test OK");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYC * 100);
        $display("Watchdog expired, the DUT stopped finishing requests");
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* src/drbg.sv */
//####################
// 128-bit DRBG
//####################
`timescale 1ns/10ps
`default_nettype none

module drbg #(
    parameter int RESEED_INTERVAL = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rng_pkg::seed_stream_s seed_i,
    output logic                  seed_ready_o,
    output rng_pkg::rand_stream_s rand_o,
    input  logic                  rand_ready_i
);
    import rng_pkg::*;

    localparam int CNT_W = $clog2(RESEED_INTERVAL + 1);

    rand_blk_t        state_q;
    logic             vld_q;     // Seeded and not yet exhausted
    logic [CNT_W-1:0] out_cnt_q;
    logic             en_q;
    logic             seed_fire;
    logic             rand_fire;

    function automatic rand_blk_t step(rand_blk_t s);
        return {s[94:0], s[127:95]} ^ (s + DRBG_ROUND_K);
    endfunction

    assign seed_ready_o = en_q && !vld_q;
    assign seed_fire    = seed_i.valid && seed_ready_o;
    assign rand_fire    = vld_q && rand_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en_q      <= 1'b0;
            vld_q     <= 1'b0;
            out_cnt_q <= '0;
        end else begin
            en_q <= 1'b1;
            if (seed_fire) begin
                vld_q     <= 1'b1;
                out_cnt_q <= '0;
            end else if (rand_fire) begin
                if (out_cnt_q == CNT_W'(RESEED_INTERVAL - 1)) begin
                    vld_q     <= 1'b0; // Interval used up, wait for a new seed
                    out_cnt_q <= '0;
                end else begin
                    out_cnt_q <= out_cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (seed_fire) state_q <= seed_i.data[255:128] ^ seed_i.data[127:0]; // Fold halves
        else if (rand_fire) state_q <= step(state_q);
    end

    assign rand_o.valid = vld_q;
    assign rand_o.data  = state_q ^ DRBG_ROUND_K;

    a_rand_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rand_o.valid && !rand_ready_i |=> rand_o.valid && $stable(rand_o.data));

endmodule

`default_nettype wire

/* src/output_buffer.sv */
//####################
// Output buffer
//####################
`timescale 1ns/10ps
`default_nettype none

module output_buffer #(
    parameter int OUTPUT_WIDTH     = 16,
    parameter int SEED_QUEUE_DEPTH = 4,
    parameter int RAW_THRESHOLD    = 12
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    force_raw_i,
    input  rng_pkg::seed_stream_s   seed_i,
    output logic                    seed_ready_o,
    input  rng_pkg::rand_stream_s   rand_i,
    output logic                    rand_ready_o,
    input  rng_pkg::raw_stream_s    raw_i,
    output logic                    raw_ready_o,
    input  logic                    req_i,
    input  rng_pkg::rand_req_t      req_type_i,
    output logic [OUTPUT_WIDTH-1:0] word_o,
    output logic                    word_valid_o,
    output logic                    busy_o
);
    import rng_pkg::*;

    localparam int SEED_SLICES = 256 / OUTPUT_WIDTH;
    localparam int RAND_SLICES = 128 / OUTPUT_WIDTH;
    localparam int SPOS_W      = $clog2(SEED_SLICES);
    localparam int RPOS_W      = $clog2(RAND_SLICES);
    localparam int PTR_W       = $clog2(SEED_QUEUE_DEPTH);

    // Seed queue with a wrap bit on each pointer
    seed_t             seed_mem [SEED_QUEUE_DEPTH];
    logic [PTR_W:0]    wr_ptr_q;
    logic [PTR_W:0]    rd_ptr_q;
    logic [PTR_W:0]    q_level;
    logic [SPOS_W-1:0] seed_pos_q;
    logic              q_full;
    logic              q_empty;
    logic              q_push;
    logic              seed_fire;
    logic              en_q;

    // RDRAND buffer
    rand_buf_u         rand_buf_q;
    buf_state_t        buf_state_q;
    logic              raw_half_q;
    logic [RPOS_W-1:0] rand_pos_q;
    logic              rand_fire;
    logic              raw_mode;

    // Host side
    ob_state_t         ob_state_q;
    logic [2:0]        words_left_q;
    logic [5:0]        demand_q;    // RDRAND minus RDSEED requests, saturating
    logic              req_acc;
    logic [2:0]        req_words;

    assign q_empty      = (wr_ptr_q == rd_ptr_q);
    assign q_full       = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W])
                       && (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
    assign q_level      = wr_ptr_q - rd_ptr_q;
    assign seed_ready_o = en_q && !q_full;
    assign q_push       = seed_i.valid && seed_ready_o;

    assign raw_mode     = force_raw_i || (demand_q >= 6'(RAW_THRESHOLD));
    assign rand_ready_o = (buf_state_q == BUF_LOAD_DRBG);
    assign raw_ready_o  = (buf_state_q == BUF_LOAD_RAW);

    assign busy_o       = (ob_state_q != OB_IDLE);
    assign req_acc      = req_i && !busy_o;
    assign req_words    = (req_type_i[1:0] == 2'b11) ? 3'd4 : {1'b0, req_type_i[1:0]};

    assign seed_fire    = (ob_state_q == OB_SEED) && !q_empty;
    assign rand_fire    = (ob_state_q == OB_RAND) && (buf_state_q == BUF_FULL);
    assign word_valid_o = seed_fire || rand_fire;

    always_comb begin
        if (ob_state_q == OB_RAND) begin
            word_o = rand_buf_q.blk[rand_pos_q * OUTPUT_WIDTH +: OUTPUT_WIDTH];
        end else begin
            word_o = seed_mem[rd_ptr_q[PTR_W-1:0]][seed_pos_q * OUTPUT_WIDTH +: OUTPUT_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en_q     <= 1'b0;
            wr_ptr_q <= '0;
        end else begin
            en_q <= 1'b1;
            if (q_push) wr_ptr_q <= wr_ptr_q + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (q_push) seed_mem[wr_ptr_q[PTR_W-1:0]] <= seed_i.data;
    end

    // Fill FSM picks the next source as the last slice leaves
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            buf_state_q <= BUF_EMPTY;
            raw_half_q  <= 1'b0;
            rand_pos_q  <= '0;
        end else begin
            case (buf_state_q)
                BUF_EMPTY: begin
                    buf_state_q <= raw_mode ? BUF_LOAD_RAW : BUF_LOAD_DRBG;
                end
                BUF_LOAD_DRBG: begin
                    if (rand_i.valid) buf_state_q <= BUF_FULL;
                end
                BUF_LOAD_RAW: begin
                    if (raw_i.valid) begin
                        raw_half_q <= ~raw_half_q;
                        if (raw_half_q) buf_state_q <= BUF_FULL; // High half done
                    end
                end
                default: begin
                    if (rand_fire) begin
                        if (rand_pos_q == RPOS_W'(RAND_SLICES - 1)) begin
                            rand_pos_q  <= '0;
                            buf_state_q <= raw_mode ? BUF_LOAD_RAW : BUF_LOAD_DRBG;
                        end else begin
                            rand_pos_q <= rand_pos_q + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rand_ready_o && rand_i.valid) rand_buf_q.blk <= rand_i.data;
        if (raw_ready_o && raw_i.valid) rand_buf_q.half[raw_half_q] <= raw_i.data;
    end

    // Host request FSM and seed slicing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ob_state_q   <= OB_IDLE;
            words_left_q <= 3'd0;
            demand_q     <= 6'd0;
            rd_ptr_q     <= '0;
            seed_pos_q   <= '0;
        end else begin
            if (req_acc) begin
                words_left_q <= req_words;
                if (req_type_i[2]) begin
                    ob_state_q <= OB_RAND;
                    if (demand_q != 6'h3f) demand_q <= demand_q + 6'd1;
                end else begin
                    ob_state_q <= OB_SEED;
                    if (demand_q != 6'h00) demand_q <= demand_q - 6'd1;
                end
            end
            if (word_valid_o) begin
                words_left_q <= words_left_q - 3'd1;
                if (words_left_q == 3'd1) ob_state_q <= OB_IDLE;
            end
            if (seed_fire) begin
                if (seed_pos_q == SPOS_W'(SEED_SLICES - 1)) begin
                    seed_pos_q <= '0;
                    rd_ptr_q   <= rd_ptr_q + 1'b1; // Head seed used up
                end else begin
                    seed_pos_q <= seed_pos_q + 1'b1;
                end
            end
        end
    end

    // Queue never holds more seeds than it has slots
    a_q_level: assert property (@(posedge clk) disable iff (!rst_n)
        q_level <= SEED_QUEUE_DEPTH);

    // A busy request always has words still to deliver
    a_busy_words: assert property (@(posedge clk) disable iff (!rst_n)
        busy_o |-> (words_left_q != 3'd0));

endmodule

`default_nettype wire

/* src/raw_noise_source.sv */
//####################
// Raw noise source
//####################
`timescale 1ns/10ps
`default_nettype none

module raw_noise_source #(
    parameter rng_pkg::raw_word_t LFSR_INIT = 64'h0000_0000_0000_0001
) (
    input  logic                 clk,
    input  logic                 rst_n,
    output rng_pkg::raw_stream_s raw_o,
    input  logic                 raw_ready_i
);
    import rng_pkg::*;

    raw_word_t lfsr_q;
    logic      valid_q;

    // Galois LFSR advanced a full word at a time
    function automatic raw_word_t lfsr_adv(raw_word_t s);
        raw_word_t x;
        x = s;
        for (int i = 0; i < 64; i++) begin
            x = x[0] ? ((x >> 1) ^ LFSR_TAPS) : (x >> 1);
        end
        return x;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr_q  <= LFSR_INIT;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1; // Noise cell is always ready once out of reset
            if (valid_q && raw_ready_i) lfsr_q <= lfsr_adv(lfsr_q);
        end
    end

    assign raw_o.valid = valid_q;
    assign raw_o.data  = lfsr_q;

    // A word on offer stays put until it is taken
    a_raw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        raw_o.valid && !raw_ready_i |=> raw_o.valid && $stable(raw_o.data));

endmodule

`default_nettype wire

/* src/rng_pkg.sv */
//####################
// RNG shared types
//####################
`default_nettype none

package rng_pkg;

    // Bit 2 selects RDRAND, low bits give 1, 2 or 4 words (2'b11 means 4)
    typedef enum logic [2:0] {
        RDSEED_16 = 3'b001,
        RDSEED_32 = 3'b010,
        RDSEED_64 = 3'b011,
        RDRAND_16 = 3'b101,
        RDRAND_32 = 3'b110,
        RDRAND_64 = 3'b111
    } rand_req_t;

    typedef logic [63:0]  raw_word_t;
    typedef logic [255:0] seed_t;
    typedef logic [127:0] rand_blk_t;

    typedef struct packed {
        logic      valid;
        raw_word_t data;
    } raw_stream_s;

    typedef struct packed {
        logic  valid;
        seed_t data;
    } seed_stream_s;

    typedef struct packed {
        logic      valid;
        rand_blk_t data;
    } rand_stream_s;

    // RDRAND buffer seen as one DRBG block or as two raw words
    typedef union packed {
        rand_blk_t           blk;
        raw_word_t [1:0]     half; // half[0] is the low word
    } rand_buf_u;

    typedef enum logic [1:0] {OB_IDLE, OB_SEED, OB_RAND} ob_state_t;

    typedef enum logic [1:0] {BUF_EMPTY, BUF_LOAD_DRBG, BUF_LOAD_RAW, BUF_FULL} buf_state_t;

    localparam raw_word_t LFSR_TAPS    = 64'hD800_0000_0000_0000; // x^64+x^63+x^61+x^60+1
    localparam int        MIX_ROT      = 13;
    localparam rand_blk_t DRBG_ROUND_K = 128'h9E37_79B9_7F4A_7C15_F39C_C060_5CED_C834;

endpackage

`default_nettype wire

/* src/rng_top.sv */
//####################
// RNG unit top
//####################
`timescale 1ns/10ps
`default_nettype none

module rng_top #(
    parameter int                 OUTPUT_WIDTH     = 16,
    parameter int                 SEED_QUEUE_DEPTH = 4,
    parameter int                 RAW_THRESHOLD    = 12,
    parameter int                 RESEED_INTERVAL  = 4,
    parameter rng_pkg::raw_word_t RAW_SEED_A       = 64'h5DEE_CE66_D1CE_4E5B,
    parameter rng_pkg::raw_word_t RAW_SEED_B       = 64'hA5A5_3C3C_0F0F_9669
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    force_raw_i,
    input  logic                    req_i,
    input  rng_pkg::rand_req_t      req_type_i,
    output logic [OUTPUT_WIDTH-1:0] word_o,
    output logic                    word_valid_o,
    output logic                    busy_o
);
    import rng_pkg::*;

    raw_stream_s  raw_a;
    raw_stream_s  raw_b;
    seed_stream_s drbg_seed;
    seed_stream_s q_seed;
    rand_stream_s rand_blk;
    logic         raw_a_ready;
    logic         raw_b_ready;
    logic         drbg_seed_ready;
    logic         q_seed_ready;
    logic         rand_ready;

    raw_noise_source #(.LFSR_INIT(RAW_SEED_A)) u_raw_a (
        .clk, .rst_n, .raw_o(raw_a), .raw_ready_i(raw_a_ready));

    raw_noise_source #(.LFSR_INIT(RAW_SEED_B)) u_raw_b ( // Fallback path
        .clk, .rst_n, .raw_o(raw_b), .raw_ready_i(raw_b_ready));

    seed_conditioner u_cond (
        .clk, .rst_n, .raw_i(raw_a), .raw_ready_o(raw_a_ready),
        .drbg_seed_o(drbg_seed), .drbg_seed_ready_i(drbg_seed_ready),
        .q_seed_o(q_seed), .q_seed_ready_i(q_seed_ready));

    drbg #(.RESEED_INTERVAL(RESEED_INTERVAL)) u_drbg (
        .clk, .rst_n, .seed_i(drbg_seed), .seed_ready_o(drbg_seed_ready),
        .rand_o(rand_blk), .rand_ready_i(rand_ready));

    output_buffer #(
        .OUTPUT_WIDTH(OUTPUT_WIDTH), .SEED_QUEUE_DEPTH(SEED_QUEUE_DEPTH),
        .RAW_THRESHOLD(RAW_THRESHOLD)
    ) u_obuf (
        .clk, .rst_n, .force_raw_i,
        .seed_i(q_seed), .seed_ready_o(q_seed_ready),
        .rand_i(rand_blk), .rand_ready_o(rand_ready),
        .raw_i(raw_b), .raw_ready_o(raw_b_ready),
        .req_i, .req_type_i, .word_o, .word_valid_o, .busy_o);

endmodule

`default_nettype wire

/* src/seed_conditioner.sv */
//####################
// Seed conditioner
//####################
`timescale 1ns/10ps
`default_nettype none

module seed_conditioner (
    input  logic                  clk,
    input  logic                  rst_n,
    input  rng_pkg::raw_stream_s  raw_i,
    output logic                  raw_ready_o,
    output rng_pkg::seed_stream_s drbg_seed_o,
    input  logic                  drbg_seed_ready_i,
    output rng_pkg::seed_stream_s q_seed_o,
    input  logic                  q_seed_ready_i
);
    import rng_pkg::*;

    raw_word_t  words_q [0:2]; // Oldest word at index 0
    logic [1:0] cnt_q;
    seed_t      seed_q;
    logic       seed_vld_q;
    logic [2:0] seed_idx_q;    // Seed index modulo 5
    logic       en_q;
    logic       to_drbg;
    logic       raw_fire;
    logic       seed_fire;

    function automatic raw_word_t rotl(raw_word_t x);
        return (x << MIX_ROT) | (x >> (64 - MIX_ROT));
    endfunction

    // First word lands in the low 64 bits
    function automatic seed_t mix(raw_word_t w0, raw_word_t w1, raw_word_t w2, raw_word_t w3);
        return {w3 ^ rotl(w0), w2 ^ rotl(w3), w1 ^ rotl(w2), w0 ^ rotl(w1)};
    endfunction

    assign to_drbg     = (seed_idx_q == 3'd0);
    assign raw_ready_o = en_q && !seed_vld_q; // Stall the source while a seed waits
    assign raw_fire    = raw_i.valid && raw_ready_o;
    assign seed_fire   = seed_vld_q && (to_drbg ? drbg_seed_ready_i : q_seed_ready_i);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            en_q       <= 1'b0;
            cnt_q      <= 2'd0;
            seed_vld_q <= 1'b0;
            seed_idx_q <= 3'd0;
        end else begin
            en_q <= 1'b1;
            if (raw_fire) begin
                cnt_q <= cnt_q + 2'd1;
                if (cnt_q == 2'd3) seed_vld_q <= 1'b1;
            end
            if (seed_fire) begin
                seed_vld_q <= 1'b0;
                seed_idx_q <= (seed_idx_q == 3'd4) ? 3'd0 : seed_idx_q + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (raw_fire) begin
            words_q[0] <= words_q[1];
            words_q[1] <= words_q[2];
            words_q[2] <= raw_i.data;
            if (cnt_q == 2'd3) seed_q <= mix(words_q[0], words_q[1], words_q[2], raw_i.data);
        end
    end

    assign drbg_seed_o.valid = seed_vld_q && to_drbg;
    assign drbg_seed_o.data  = seed_q;
    assign q_seed_o.valid    = seed_vld_q && !to_drbg;
    assign q_seed_o.data     = seed_q;

    // A finished seed and its route hold until the destination takes it
    a_seed_hold: assert property (@(posedge clk) disable iff (!rst_n)
        seed_vld_q && !seed_fire |=> seed_vld_q && $stable(seed_q) && $stable(to_drbg));

endmodule

`default_nettype wire
